//--- src/cpu_types_pkg.sv
package cpu_types_pkg;

  // Data word for operands and results
  typedef logic [31:0] word_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Opcode field, only four codes are defined
  typedef logic [2:0] op_t;

  // Defined opcodes
  localparam op_t OP_ADD = 3'd0;
  localparam op_t OP_SUB = 3'd1;
  localparam op_t OP_XOR = 3'd2;
  // Goes to the multiplier, everything else to the ALU
  localparam op_t OP_MUL = 3'd3;

  // Codes 4 to 7 are undefined and complete with an exception

endpackage

//--- src/cb_ctrl_pkg.sv
package cb_ctrl_pkg;

  import cpu_types_pkg::*;

  // Entry index field width, bounds the buffer at 16 entries
  localparam int CB_IDX_W = 4;

  typedef logic [CB_IDX_W-1:0] cb_idx_t;

  // Incoming instruction
  typedef struct packed {
    op_t      op;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
  } instr_t;

  // Writeback from an execution unit, addressed by entry index
  typedef struct packed {
    logic     valid;
    cb_idx_t  idx;
    reg_idx_t rd;
    word_t    data;
    logic     exception;
  } fu_result_t;

  // Issue control states
  typedef enum logic [1:0] {RUN, DRAIN, RESTORE} issue_state_e;

endpackage

//--- src/latency_timer.sv
`timescale 1ns/1ns

module latency_timer #(
  parameter int MUL_STEPS = 32
) (
  input  logic CLK,
  input  logic nRST,
  input  logic start,
  output logic busy,
  output logic last
);

  // Wide enough to hold MUL_STEPS itself
  localparam int CNT_W = $clog2(MUL_STEPS + 1);

  logic [CNT_W-1:0] count_q;

  // Load on start, then count down to zero
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count_q <= '0;
    end else if (start) begin
      count_q <= CNT_W'(MUL_STEPS);
    end else if (busy) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign busy = count_q != '0;
  // Final step of the iteration
  assign last = count_q == CNT_W'(1);

endmodule

//--- src/alu_unit.sv
`timescale 1ns/1ns

module alu_unit
  import cpu_types_pkg::*, cb_ctrl_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       flush,
  input  logic       issue,
  input  instr_t     instr,
  input  cb_idx_t    idx,
  output fu_result_t result
);

  word_t alu_data;
  logic  alu_exc;

  // Single-cycle datapath
  always_comb begin
    alu_data = '0;
    alu_exc  = 1'b0;
    case (instr.op)
      OP_ADD: alu_data = instr.a + instr.b;
      OP_SUB: alu_data = instr.a - instr.b;
      OP_XOR: alu_data = instr.a ^ instr.b;
      // Undefined codes, data stays zero
      default: alu_exc = 1'b1;
    endcase
  end

  // Result register, a flush kills whatever is being issued
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result <= '0;
    end else begin
      result <= fu_result_t'{valid: issue & ~flush, idx: idx, rd: instr.rd,
                             data: alu_data, exception: alu_exc};
    end
  end

endmodule

//--- src/mul_unit.sv
`timescale 1ns/1ns

module mul_unit
  import cpu_types_pkg::*, cb_ctrl_pkg::*;
#(
  parameter int MUL_STEPS = 32
) (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       flush,
  input  logic       issue,
  input  instr_t     instr,
  input  cb_idx_t    idx,
  output fu_result_t result,
  output logic       done
);

  word_t    mcand_q, mplier_q, acc_q, acc_next;
  reg_idx_t rd_q;
  cb_idx_t  idx_q;
  logic     kill_q, tmr_busy, tmr_last;

  // One shift-add step per timer cycle
  latency_timer #(
    .MUL_STEPS(MUL_STEPS)
  ) u_latency_timer (
    .CLK  (CLK),
    .nRST (nRST),
    .start(issue),
    .busy (tmr_busy),
    .last (tmr_last)
  );

  // Add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = acc_q + (mplier_q[0] ? mcand_q : '0);

  // Operand and partial sum registers
  always_ff @(posedge CLK) begin
    if (issue) begin
      mcand_q  <= instr.a;
      mplier_q <= instr.b;
      acc_q    <= '0;
      rd_q     <= instr.rd;
      idx_q    <= idx;
    end else if (tmr_busy) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      acc_q    <= acc_next;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      kill_q <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      // Credit comes back even for an abandoned operation
      done   <= tmr_last;
      // Low 32 bits of the product land here after the last step
      result <= fu_result_t'{valid: tmr_last & ~kill_q & ~flush, idx: idx_q, rd: rd_q,
                             data: acc_next, exception: 1'b0};
      // Remember a flush seen mid-operation
      if (issue) begin
        kill_q <= 1'b0;
      end else if (flush && tmr_busy) begin
        kill_q <= 1'b1;
      end
    end
  end

endmodule

//--- src/completion_buffer.sv
`timescale 1ns/1ns

module completion_buffer
  import cpu_types_pkg::*, cb_ctrl_pkg::*;
#(
  parameter int NUM_ENTRY = 8
) (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       alloc,
  input  reg_idx_t   alloc_rd,
  output cb_idx_t    tail_idx,
  input  fu_result_t alu_res,
  input  fu_result_t mul_res,
  output logic       commit_valid,
  output reg_idx_t   commit_rd,
  output word_t      commit_data,
  output logic       exc_valid,
  output reg_idx_t   exc_rd,
  output logic       flush
);

  localparam int IDX_BITS = $clog2(NUM_ENTRY);

  // Payload held per entry
  typedef struct packed {
    logic     exc;
    reg_idx_t rd;
    word_t    data;
  } cb_slot_t;

  // Pointers carry one extra wrap bit
  logic [IDX_BITS:0]    head_q, tail_q;
  logic [IDX_BITS-1:0]  head_sel, tail_sel, alu_sel, mul_sel;
  logic [NUM_ENTRY-1:0] done_q, done_d;
  cb_slot_t             slot_q [NUM_ENTRY];
  logic                 full, empty, alloc_ok, head_ready;

  assign head_sel = head_q[IDX_BITS-1:0];
  assign tail_sel = tail_q[IDX_BITS-1:0];
  assign alu_sel  = alu_res.idx[IDX_BITS-1:0];
  assign mul_sel  = mul_res.idx[IDX_BITS-1:0];

  // Same slot, opposite wrap bit means full
  assign empty    = head_q == tail_q;
  assign full     = (head_sel == tail_sel) && (head_q[IDX_BITS] != tail_q[IDX_BITS]);
  assign alloc_ok = alloc & ~full;
  assign tail_idx = cb_idx_t'(tail_sel);

  // Head entry decides between commit and exception
  assign head_ready   = ~empty & done_q[head_sel];
  assign commit_valid = head_ready & ~slot_q[head_sel].exc;
  assign commit_rd    = slot_q[head_sel].rd;
  assign commit_data  = slot_q[head_sel].data;
  assign exc_valid    = head_ready & slot_q[head_sel].exc;
  assign exc_rd       = slot_q[head_sel].rd;
  assign flush        = exc_valid;

  // Done flags, writebacks land after the allocation clear
  always_comb begin
    done_d = done_q;
    if (commit_valid) begin
      done_d[head_sel] = 1'b0;
    end
    if (alloc_ok) begin
      done_d[tail_sel] = 1'b0;
    end
    // Both units may finish in the same cycle
    if (alu_res.valid) begin
      done_d[alu_sel] = 1'b1;
    end
    if (mul_res.valid) begin
      done_d[mul_sel] = 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end else if (flush) begin
      // Exception at head drops every younger entry
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end else begin
      head_q <= head_q + (IDX_BITS+1)'(commit_valid);
      tail_q <= tail_q + (IDX_BITS+1)'(alloc_ok);
      done_q <= done_d;
    end
  end

  // Entry payload
  always_ff @(posedge CLK) begin
    if (alloc_ok) begin
      slot_q[tail_sel] <= cb_slot_t'{exc: 1'b0, rd: alloc_rd, data: '0};
    end
    if (alu_res.valid) begin
      slot_q[alu_sel] <= cb_slot_t'{exc: alu_res.exception, rd: alu_res.rd,
                                    data: alu_res.data};
    end
    if (mul_res.valid) begin
      slot_q[mul_sel] <= cb_slot_t'{exc: mul_res.exception, rd: mul_res.rd,
                                    data: mul_res.data};
    end
  end

endmodule

//--- src/issue_fsm.sv
`timescale 1ns/1ns

module issue_fsm
  import cpu_types_pkg::*, cb_ctrl_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    in_valid,
  input  instr_t  in_instr,
  input  cb_idx_t tail_idx,
  input  logic    flush,
  input  logic    mul_busy,
  output logic    alloc,
  output logic    alu_issue,
  output logic    mul_issue,
  output logic    credit_reset
);

  issue_state_e state_q, state_d;
  logic         is_mul;

  assign is_mul = in_instr.op == OP_MUL;

  // Accept only in RUN, never in the flush cycle itself
  assign alloc     = (state_q == RUN) & in_valid & ~flush;
  // Steer by opcode, undefined codes go to the ALU
  assign mul_issue = alloc & is_mul;
  assign alu_issue = alloc & ~is_mul;

  // Single-cycle pulse back to the sender
  assign credit_reset = state_q == RESTORE;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (flush) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // Multiplier quiet and buffer tail back at slot 0
        if (!mul_busy && tail_idx == '0) begin
          state_d = RESTORE;
        end
      end
      RESTORE: state_d = RUN;
      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- src/cb_subsys_top.sv
`timescale 1ns/1ns

module cb_subsys_top
  import cpu_types_pkg::*, cb_ctrl_pkg::*;
#(
  parameter int NUM_ENTRY = 8,
  // One multiplier bit per step
  parameter int MUL_STEPS = 32
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     in_valid,
  input  instr_t   in_instr,
  output logic     buf_credit,
  output logic     mul_credit,
  output logic     credit_reset,
  output logic     commit_valid,
  output reg_idx_t commit_rd,
  output word_t    commit_data,
  output logic     exc_valid,
  output reg_idx_t exc_rd
);

  logic       alloc, alu_issue, mul_issue, flush, mul_done, mul_pending;
  cb_idx_t    tail_idx;
  fu_result_t alu_res, mul_res;

  // Every commit frees one buffer slot
  assign buf_credit = commit_valid;
  assign mul_credit = mul_done;

  // Multiplier occupied from issue until its done pulse
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mul_pending <= 1'b0;
    end else if (mul_issue) begin
      mul_pending <= 1'b1;
    end else if (mul_done) begin
      mul_pending <= 1'b0;
    end
  end

  issue_fsm u_issue_fsm (
    .CLK(CLK), .nRST(nRST), .in_valid(in_valid), .in_instr(in_instr),
    .tail_idx(tail_idx), .flush(flush), .mul_busy(mul_pending), .alloc(alloc),
    .alu_issue(alu_issue), .mul_issue(mul_issue), .credit_reset(credit_reset)
  );

  completion_buffer #(.NUM_ENTRY(NUM_ENTRY)) u_completion_buffer (
    .CLK(CLK), .nRST(nRST), .alloc(alloc), .alloc_rd(in_instr.rd), .tail_idx(tail_idx),
    .alu_res(alu_res), .mul_res(mul_res), .commit_valid(commit_valid),
    .commit_rd(commit_rd), .commit_data(commit_data), .exc_valid(exc_valid),
    .exc_rd(exc_rd), .flush(flush)
  );

  // Both units take the freshly allocated tail index
  alu_unit u_alu_unit (
    .CLK(CLK), .nRST(nRST), .flush(flush), .issue(alu_issue), .instr(in_instr),
    .idx(tail_idx), .result(alu_res)
  );

  mul_unit #(.MUL_STEPS(MUL_STEPS)) u_mul_unit (
    .CLK(CLK), .nRST(nRST), .flush(flush), .issue(mul_issue), .instr(in_instr),
    .idx(tail_idx), .result(mul_res), .done(mul_done)
  );

endmodule

//--- sim/cb_subsys_props.sv
`timescale 1ns/1ns

module cb_subsys_props (
  input logic CLK,
  input logic nRST,
  input logic alloc,
  input logic commit_valid,
  input logic exc_valid,
  input logic flush,
  input logic empty,
  input logic full
);

  int fail_count = 0;

  // A commit needs a live head entry
  assert property (@(posedge CLK) disable iff (!nRST) commit_valid |-> !empty)
    else begin
      $error("commit while the completion buffer is empty");
      fail_count++;
    end

  // Sender credits keep allocation out of a full ring
  assert property (@(posedge CLK) disable iff (!nRST) alloc |-> !full)
    else begin
      $error("alloc while the completion buffer is full");
      fail_count++;
    end

  assert property (@(posedge CLK) disable iff (!nRST) flush |=> empty)
    else begin
      $error("completion buffer not empty after flush");
      fail_count++;
    end

  // Head either commits or raises the exception
  assert property (@(posedge CLK) disable iff (!nRST) !(exc_valid && commit_valid))
    else begin
      $error("exc_valid and commit_valid high together");
      fail_count++;
    end

endmodule

bind completion_buffer cb_subsys_props u_cb_subsys_props (
  .CLK(CLK), .nRST(nRST), .alloc(alloc), .commit_valid(commit_valid),
  .exc_valid(exc_valid), .flush(flush), .empty(empty), .full(full)
);

//--- sim/cb_subsys_tb.sv
`timescale 1ns/1ns

module cb_subsys_tb
  import cpu_types_pkg::*, cb_ctrl_pkg::*;
();

  localparam int NUM_ENTRY  = 8;
  localparam int MUL_STEPS  = 32;
  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 400;

  // Expected retirement of one instruction
  typedef struct packed {
    logic     exc;
    reg_idx_t rd;
    word_t    data;
  } expect_t;

  logic     CLK, nRST, in_valid;
  instr_t   in_instr;
  logic     buf_credit, mul_credit, credit_reset, commit_valid, exc_valid;
  reg_idx_t commit_rd, exc_rd;
  word_t    commit_data;

  // Reference queue in program order
  expect_t     ref_q[$];
  int          buf_cred, mul_cred, buf_pulses, mul_pulses, exc_count, reset_count;
  int          checks, errors;
  logic        recovering;
  logic [31:0] rng_state;

  cb_subsys_top #(.NUM_ENTRY(NUM_ENTRY), .MUL_STEPS(MUL_STEPS)) u_cb_subsys_top (
    .CLK(CLK), .nRST(nRST), .in_valid(in_valid), .in_instr(in_instr),
    .buf_credit(buf_credit), .mul_credit(mul_credit), .credit_reset(credit_reset),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
    .exc_valid(exc_valid), .exc_rd(exc_rd)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output word_t v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  // Result as the opcode definitions give it
  function automatic word_t model_result(input instr_t ins);
    case (ins.op)
      OP_ADD:  return ins.a + ins.b;
      OP_SUB:  return ins.a - ins.b;
      OP_XOR:  return ins.a ^ ins.b;
      // keeps the low 32 bits of the product
      OP_MUL:  return ins.a * ins.b;
      default: return '0;
    endcase
  endfunction

  function automatic instr_t build_instr(input op_t op, input reg_idx_t rd,
                                         input word_t a, input word_t b);
    return instr_t'{op: op, rd: rd, a: a, b: b};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic retire_commit();
    expect_t e;
    if (ref_q.size() == 0) begin
      errors++;
      $display("Commit of rd %0d at %0t ns with nothing outstanding", commit_rd, $time);
      return;
    end
    e = ref_q.pop_front();
    if (e.exc) begin
      errors++;
      $display("Commit at %0t ns where an exception was expected", $time);
    end
    check_value("commit_rd", 32'(commit_rd), 32'(e.rd));
    check_value("commit_data", commit_data, e.data);
  endtask

  task automatic take_exception();
    if (ref_q.size() == 0 || !ref_q[0].exc) begin
      errors++;
      $display("Exception on rd %0d at %0t ns where none was expected", exc_rd, $time);
    end else begin
      check_value("exc_rd", 32'(exc_rd), 32'(ref_q[0].rd));
    end
    // Younger entries never retire
    ref_q.delete();
    buf_cred   = 0;
    mul_cred   = 0;
    recovering = 1'b1;
    exc_count++;
  endtask

  // Mid-cycle monitor for commits and credit pulses
  always @(negedge CLK) begin
    if (nRST) begin
      if (exc_valid) take_exception();
      if (commit_valid) retire_commit();
      if (buf_credit) begin
        buf_pulses++;
        if (!recovering) buf_cred++;
      end
      // Credits returned during recovery are replaced by the reset
      if (mul_credit) begin
        mul_pulses++;
        if (!recovering) mul_cred++;
      end
      if (credit_reset) begin
        buf_cred   = NUM_ENTRY;
        mul_cred   = 1;
        recovering = 1'b0;
        reset_count++;
      end
    end
  end

  // Sender holds in_valid for one cycle once the needed credits are there
  task automatic send_instr(input instr_t ins);
    int      waited;
    logic    need_mul;
    expect_t e;
    waited   = 0;
    need_mul = ins.op == OP_MUL;
    while (exc_valid || recovering || buf_cred == 0 || (need_mul && mul_cred == 0)) begin
      if (waited == WAIT_LIMIT) begin
        errors++;
        $display("Timed out waiting for credit to send rd %0d at %0t ns", ins.rd, $time);
        return;
      end
      waited++;
      @(posedge CLK);
      #5;
    end
    e.exc  = !(ins.op inside {OP_ADD, OP_SUB, OP_XOR, OP_MUL});
    e.rd   = ins.rd;
    e.data = model_result(ins);
    ref_q.push_back(e);
    buf_cred--;
    if (need_mul) mul_cred--;
    in_valid = 1'b1;
    in_instr = ins;
    @(posedge CLK);
    #5;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int waited;
    waited = 0;
    while (ref_q.size() != 0) begin
      if (waited == WAIT_LIMIT) begin
        errors++;
        $display("Timed out waiting for %s to commit", what);
        return;
      end
      waited++;
      @(posedge CLK);
      #5;
    end
  endtask

  task automatic wait_restore(input int resets_before);
    int waited;
    waited = 0;
    while (reset_count == resets_before) begin
      if (waited == WAIT_LIMIT) begin
        errors++;
        $display("Timed out waiting for credit_reset after the exception");
        return;
      end
      waited++;
      @(posedge CLK);
      #5;
    end
  endtask

  // Edge operands one at a time
  task automatic single_alu_test();
    send_instr(build_instr(OP_ADD, 5'd1, 32'hffff_ffff, 32'h0000_0001));
    wait_drained("add");
    send_instr(build_instr(OP_SUB, 5'd2, 32'h0000_0000, 32'h0000_0001));
    wait_drained("sub");
    send_instr(build_instr(OP_XOR, 5'd31, 32'haaaa_aaaa, 32'h5555_5555));
    wait_drained("xor");
    send_instr(build_instr(OP_ADD, 5'd0, 32'h7fff_ffff, 32'h7fff_ffff));
    wait_drained("add overflow");
  endtask

  // ALU ops finish first but retire behind the product
  task automatic mul_order_test();
    send_instr(build_instr(OP_MUL, 5'd7, 32'h1234_5678, 32'h9abc_def0));
    send_instr(build_instr(OP_ADD, 5'd8, 32'd5, 32'd6));
    send_instr(build_instr(OP_SUB, 5'd9, 32'd5, 32'd6));
    send_instr(build_instr(OP_XOR, 5'd10, 32'hdead_beef, 32'hffff_0000));
    wait_drained("multiply then ALU");
    send_instr(build_instr(OP_MUL, 5'd11, 32'hffff_ffff, 32'hffff_ffff));
    wait_drained("all-ones multiply");
  endtask

  task automatic credit_drain_test();
    int start_pulses, start_mul;
    start_pulses = buf_pulses;
    start_mul    = mul_pulses;
    // Product at the head holds every later entry in the buffer
    send_instr(build_instr(OP_MUL, 5'd16, 32'd3000, 32'd70001));
    for (int i = 1; i < NUM_ENTRY; i++) begin
      send_instr(build_instr(OP_XOR, 5'(16 + i), 32'(i), 32'h0f0f_0f0f));
    end
    check_value("buf_cred", buf_cred, 0);
    wait_drained("full buffer");
    check_value("buf_credit pulses", buf_pulses - start_pulses, NUM_ENTRY);
    check_value("mul_credit pulses", mul_pulses - start_mul, 1);
    check_value("buf_cred", buf_cred, NUM_ENTRY);
  endtask

  task automatic exception_flush_test();
    int resets_before, exc_before, pulses_before, mul_before;
    resets_before = reset_count;
    exc_before    = exc_count;
    pulses_before = buf_pulses;
    mul_before    = mul_pulses;
    // Older ops retire first
    send_instr(build_instr(OP_ADD, 5'd3, 32'd10, 32'd20));
    send_instr(build_instr(OP_MUL, 5'd4, 32'd7, 32'd6));
    send_instr(build_instr(3'd5, 5'd12, 32'd1, 32'd2));
    // Younger ops behind the exception
    // The last multiply is abandoned in flight
    send_instr(build_instr(OP_ADD, 5'd13, 32'd1, 32'd1));
    send_instr(build_instr(OP_XOR, 5'd14, 32'd1, 32'd3));
    send_instr(build_instr(OP_MUL, 5'd15, 32'd9, 32'd9));
    wait_restore(resets_before);
    check_value("exception count", exc_count - exc_before, 1);
    // Only the two older ops free a slot
    check_value("buf_credit pulses", buf_pulses - pulses_before, 2);
    // One finished and one abandoned multiply
    check_value("mul_credit pulses", mul_pulses - mul_before, 2);
  endtask

  task automatic random_mix_test();
    word_t r, a, b;
    op_t   op_pick[4] = '{OP_ADD, OP_SUB, OP_XOR, OP_MUL};
    for (int n = 0; n < 40; n++) begin
      next_random(r);
      next_random(a);
      next_random(b);
      send_instr(build_instr(op_pick[r[1:0]], r[6:2], a, b));
    end
    wait_drained("random mix");
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    in_valid    = 1'b0;
    in_instr    = '0;
    buf_cred    = NUM_ENTRY;
    mul_cred    = 1;
    buf_pulses  = 0;
    mul_pulses  = 0;
    exc_count   = 0;
    reset_count = 0;
    checks      = 0;
    errors      = 0;
    recovering  = 1'b0;
    rng_state   = 32'h2d1b94db;
    repeat (2) @(posedge CLK);
    #5;
    nRST = 1'b1;
    single_alu_test();
    mul_order_test();
    credit_drain_test();
    exception_flush_test();
    random_mix_test();
    check_value("credit_reset count", reset_count, 1);
    errors = errors + u_cb_subsys_top.u_completion_buffer.u_cb_subsys_props.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
src/cpu_types_pkg.sv
src/cb_ctrl_pkg.sv
src/latency_timer.sv
src/alu_unit.sv
src/mul_unit.sv
src/completion_buffer.sv
src/issue_fsm.sv
src/cb_subsys_top.sv
sim/cb_subsys_props.sv
sim/cb_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module cb_subsys_tb -o cb_subsys_sim

# Keep running past assertion errors so the testbench prints its report
output="$(./obj_dir/cb_subsys_sim +verilator+error+limit+100)" || true
echo "$output"

grep -q "^TEST PASSED$" <<< "$output"
